// File: design/io_addr_pkg.sv
// Address-map constants, memory select enum and the D write-address union
package io_addr_pkg;

    // Widths of the thread-level addresses and of a memory's local space
    localparam int read_addr_width  = 11;
    localparam int write_addr_width = 12;
    localparam int mem_addr_width   = 10;
    localparam int split_half_width = 6;   // Each half of a split D address

    // Memory A reads below memory B
    localparam logic [read_addr_width-1:0] mem_read_base_a  = 11'd0;
    localparam logic [read_addr_width-1:0] mem_read_bound_a = 11'd1023;
    localparam logic [read_addr_width-1:0] mem_read_base_b  = 11'd1024;
    localparam logic [read_addr_width-1:0] mem_read_bound_b = 11'd2047;

    // Write ranges share the read map, but on the wider D address
    localparam logic [write_addr_width-1:0] mem_write_base_a  = 12'd0;
    localparam logic [write_addr_width-1:0] mem_write_bound_a = 12'd1023;
    localparam logic [write_addr_width-1:0] mem_write_base_b  = 12'd1024;
    localparam logic [write_addr_width-1:0] mem_write_bound_b = 12'd2047;

    // Which data memory a decoder serves
    typedef enum logic {
        mem_a = 1'b0,
        mem_b = 1'b1
    } mem_sel_e;

    // A split D word carries one short address per memory
    typedef struct packed {
        logic [split_half_width-1:0] hi;   // Goes to memory A
        logic [split_half_width-1:0] lo;   // Goes to memory B
    } write_halves_t;

    // The D word is read either whole or as two halves, depending on split
    typedef union packed {
        logic [write_addr_width-1:0] full;
        write_halves_t               halves;
    } write_addr_u;

endpackage

// File: design/io_port_pkg.sv
// I/O port window constants, port index and flag vector types, decoded request struct
package io_port_pkg;

    // Four ports per memory, at local addresses 60 to 63
    localparam int port_count      = 4;
    localparam int port_addr_width = 2;
    localparam int port_base_addr  = 60;   // Reachable from a 6-bit split half

    typedef logic [port_addr_width-1:0] port_idx_t;

    // One bit per port, used for flags and for read strobes
    typedef logic [port_count-1:0] port_vec_t;

    // Decoded access of one thread to one memory
    typedef struct packed {
        logic      read_en;       // Read address falls in this memory
        logic      read_is_io;    // Read hits the port window
        port_idx_t read_port;
        logic      write_en;      // Write address falls in this memory
        logic      write_is_io;   // Write hits the port window
        port_idx_t write_port;
    } mem_req_t;

endpackage

// File: design/mem_address_decoder.sv
// Address decoder for one data memory: range checks, split translation, port window decode
module mem_address_decoder
    import io_addr_pkg::*;
    import io_port_pkg::*;
(
    input  mem_sel_e                   mem,
    input  logic                       split,
    input  logic [read_addr_width-1:0] read_addr,
    input  write_addr_u                write_addr,
    output mem_req_t                   req
);

    logic [read_addr_width-1:0]  read_base;
    logic [read_addr_width-1:0]  read_bound;
    logic [write_addr_width-1:0] write_base;
    logic [write_addr_width-1:0] write_bound;
    logic [read_addr_width-1:0]  read_offset;
    logic [write_addr_width-1:0] write_offset;
    logic [split_half_width-1:0] split_half;
    logic [mem_addr_width-1:0]   read_local;
    logic [mem_addr_width-1:0]   write_local;
    logic                        read_en;
    logic                        write_en;

    // Anything at or above the port base is treated as I/O
    function automatic logic is_port(logic [mem_addr_width-1:0] local_addr);
        return local_addr >= mem_addr_width'(port_base_addr);
    endfunction

    function automatic port_idx_t port_of(logic [mem_addr_width-1:0] local_addr);
        logic [mem_addr_width-1:0] offset;
        offset = local_addr - mem_addr_width'(port_base_addr);
        return offset[port_addr_width-1:0];
    endfunction

    always_comb begin
        if (mem == mem_a) begin
            read_base   = mem_read_base_a;
            read_bound  = mem_read_bound_a;
            write_base  = mem_write_base_a;
            write_bound = mem_write_bound_a;
        end else begin
            read_base   = mem_read_base_b;
            read_bound  = mem_read_bound_b;
            write_base  = mem_write_base_b;
            write_bound = mem_write_bound_b;
        end
    end

    assign read_en     = (read_addr >= read_base) && (read_addr <= read_bound);
    assign read_offset = read_addr - read_base;
    assign read_local  = read_offset[mem_addr_width-1:0];   // Drop the memory select bit

    // Memory A owns the upper half of a split D, memory B the lower half
    assign split_half   = (mem == mem_a) ? write_addr.halves.hi : write_addr.halves.lo;
    assign write_offset = write_addr.full - write_base;

    always_comb begin
        if (split) begin
            write_en    = 1'b1;                              // Both memories always write
            write_local = mem_addr_width'(split_half);       // Zero-extended half
        end else begin
            write_en    = (write_addr.full >= write_base) && (write_addr.full <= write_bound);
            write_local = write_offset[mem_addr_width-1:0];
        end
    end

    always_comb begin
        req.read_en     = read_en;
        req.read_is_io  = read_en && is_port(read_local);
        req.read_port   = port_of(read_local);
        req.write_en    = write_en;
        req.write_is_io = write_en && is_port(write_local);
        req.write_port  = port_of(write_local);
    end

    // A split half hits the window exactly when its top bits are all set, and its low bits name the port
    split_write_port: assert final (!split || (req.write_en &&
        (req.write_is_io == (&split_half[split_half_width-1:port_addr_width])) &&
        (!req.write_is_io || (req.write_port == split_half[port_addr_width-1:0]))))
        else $error("Split write decoded to the wrong port or without write enable");

endmodule

// File: design/io_decode_stage.sv
// One-cycle pipeline register for the decoded requests of memories A and B
module io_decode_stage
    import io_port_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  mem_req_t req_a,
    input  mem_req_t req_b,
    output mem_req_t req_a_q,
    output mem_req_t req_b_q
);

    // Lines the decode up with the memory read stage
    always_ff @(posedge clock) begin
        if (rst) begin
            req_a_q <= '0;   // No I/O access pending after reset
            req_b_q <= '0;
        end else begin
            req_a_q <= req_a;
            req_b_q <= req_b;
        end
    end

    // An I/O hit decoded in one cycle arrives with its enable in the next
    io_needs_en_a: assert property (
        @(posedge clock) disable iff (rst)
        (req_a.read_is_io || req_a.write_is_io) |=>
            (!req_a_q.read_is_io || req_a_q.read_en) &&
            (!req_a_q.write_is_io || req_a_q.write_en)
    ) else $error("Memory A request has is_io without its enable");

    io_needs_en_b: assert property (
        @(posedge clock) disable iff (rst)
        (req_b.read_is_io || req_b.write_is_io) |=>
            (!req_b_q.read_is_io || req_b_q.read_en) &&
            (!req_b_q.write_is_io || req_b_q.write_en)
    ) else $error("Memory B request has is_io without its enable");

endmodule

// File: design/io_ready_gate.sv
// Flag masking, io_ready reduction, gated read strobes and is-I/O outputs
module io_ready_gate
    import io_port_pkg::*;
(
    input  logic      clock,   // Used by the assertions only
    input  mem_req_t  req_a_q,
    input  mem_req_t  req_b_q,
    input  port_vec_t read_ef_a,
    input  port_vec_t read_ef_b,
    input  port_vec_t write_ef_a,
    input  port_vec_t write_ef_b,
    output port_vec_t io_rden_a,
    output port_vec_t io_rden_b,
    output logic      read_addr_is_io_a,
    output logic      read_addr_is_io_b,
    output logic      write_addr_is_io_a,
    output logic      write_addr_is_io_b,
    output logic      io_ready
);

    logic read_ok_a;
    logic read_ok_b;
    logic write_ok_a;
    logic write_ok_b;

    // A non-I/O access never waits on a port
    function automatic logic masked_flag(logic is_io, port_idx_t port, port_vec_t ef);
        return is_io ? ef[port] : 1'b1;
    endfunction

    function automatic port_vec_t strobe(logic fire, port_idx_t port);
        return fire ? (port_vec_t'(1) << port) : '0;
    endfunction

    assign read_ok_a  = masked_flag(req_a_q.read_is_io, req_a_q.read_port, read_ef_a);
    assign read_ok_b  = masked_flag(req_b_q.read_is_io, req_b_q.read_port, read_ef_b);
    assign write_ok_a = masked_flag(req_a_q.write_is_io, req_a_q.write_port, write_ef_a);
    assign write_ok_b = masked_flag(req_b_q.write_is_io, req_b_q.write_port, write_ef_b);

    // All four accesses of the thread must be able to proceed together
    assign io_ready = read_ok_a && read_ok_b && write_ok_a && write_ok_b;

    assign io_rden_a = strobe(req_a_q.read_is_io && io_ready, req_a_q.read_port);
    assign io_rden_b = strobe(req_b_q.read_is_io && io_ready, req_b_q.read_port);

    assign read_addr_is_io_a  = req_a_q.read_is_io;
    assign read_addr_is_io_b  = req_b_q.read_is_io;
    assign write_addr_is_io_a = req_a_q.write_is_io;
    assign write_addr_is_io_b = req_b_q.write_is_io;

    // A strobe pops a port FIFO, so at most one may fire and never on an empty port
    rden_safe_a: assert property (
        @(posedge clock) (|io_rden_a) |->
            $onehot(io_rden_a) && ((io_rden_a & read_ef_a) == io_rden_a)
    ) else $error("Memory A read strobe not one-hot or fired on an empty port");

    rden_safe_b: assert property (
        @(posedge clock) (|io_rden_b) |->
            $onehot(io_rden_b) && ((io_rden_b & read_ef_b) == io_rden_b)
    ) else $error("Memory B read strobe not one-hot or fired on an empty port");

endmodule

// File: design/datapath_io_predication.sv
// Top level of the I/O predication block: two decoders, the decode stage and the ready gate
module datapath_io_predication
    import io_addr_pkg::*;
    import io_port_pkg::*;
(
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        split,
    input  logic [read_addr_width-1:0]  read_addr_a,
    input  logic [read_addr_width-1:0]  read_addr_b,
    input  logic [write_addr_width-1:0] write_addr_d,
    input  port_vec_t                   read_ef_a,
    input  port_vec_t                   read_ef_b,
    input  port_vec_t                   write_ef_a,
    input  port_vec_t                   write_ef_b,
    output port_vec_t                   io_rden_a,
    output port_vec_t                   io_rden_b,
    output logic                        read_addr_is_io_a,
    output logic                        read_addr_is_io_b,
    output logic                        write_addr_is_io_a,
    output logic                        write_addr_is_io_b,
    output logic                        io_ready
);

    mem_req_t req_a;
    mem_req_t req_b;
    mem_req_t req_a_q;
    mem_req_t req_b_q;

    mem_address_decoder dec_a (
        .mem        (mem_a),   // Takes the hi half of a split D
        .split      (split),
        .read_addr  (read_addr_a),
        .write_addr (write_addr_d),
        .req        (req_a)
    );

    mem_address_decoder dec_b (
        .mem        (mem_b),   // Takes the lo half of a split D
        .split      (split),
        .read_addr  (read_addr_b),
        .write_addr (write_addr_d),
        .req        (req_b)
    );

    io_decode_stage stage0 (
        .clock   (clock),
        .rst     (rst),
        .req_a   (req_a),
        .req_b   (req_b),
        .req_a_q (req_a_q),
        .req_b_q (req_b_q)
    );

    // Flags are sampled one cycle after the addresses, against the registered decode
    io_ready_gate gate0 (
        .clock              (clock),
        .req_a_q            (req_a_q),
        .req_b_q            (req_b_q),
        .read_ef_a          (read_ef_a),
        .read_ef_b          (read_ef_b),
        .write_ef_a         (write_ef_a),
        .write_ef_b         (write_ef_b),
        .io_rden_a          (io_rden_a),
        .io_rden_b          (io_rden_b),
        .read_addr_is_io_a  (read_addr_is_io_a),
        .read_addr_is_io_b  (read_addr_is_io_b),
        .write_addr_is_io_a (write_addr_is_io_a),
        .write_addr_is_io_b (write_addr_is_io_b),
        .io_ready           (io_ready)
    );

endmodule

// File: tb/tb_datapath_io_predication.sv
// Testbench for datapath_io_predication: directed table, random rows, rule model, watchdog
module tb_datapath_io_predication
    import io_addr_pkg::*;
    import io_port_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clock_period = 8;
    localparam int table_rows   = 12;
    localparam int random_rows  = 200;
    localparam int watchdog_ns  = (table_rows + random_rows + 20) * clock_period;

    // One test step: inputs, then the outputs expected one cycle after the addresses
    typedef struct packed {
        logic                        split;
        logic [read_addr_width-1:0]  ra_a;
        logic [read_addr_width-1:0]  ra_b;
        logic [write_addr_width-1:0] d;
        port_vec_t                   ref_a;
        port_vec_t                   ref_b;
        port_vec_t                   wef_a;
        port_vec_t                   wef_b;
        port_vec_t                   rden_a;
        port_vec_t                   rden_b;
        logic [3:0]                  io;      // {read A, read B, write A, write B}
        logic                        ready;
    } row_t;

    logic                        clock;
    logic                        rst;
    logic                        split;
    logic [read_addr_width-1:0]  read_addr_a;
    logic [read_addr_width-1:0]  read_addr_b;
    logic [write_addr_width-1:0] write_addr_d;
    port_vec_t                   read_ef_a;
    port_vec_t                   read_ef_b;
    port_vec_t                   write_ef_a;
    port_vec_t                   write_ef_b;
    port_vec_t                   io_rden_a;
    port_vec_t                   io_rden_b;
    logic                        read_addr_is_io_a;
    logic                        read_addr_is_io_b;
    logic                        write_addr_is_io_a;
    logic                        write_addr_is_io_b;
    logic                        io_ready;

    row_t   rows[$];
    integer seed;
    int     checks;
    int     errors;

    datapath_io_predication dut0 (
        .clock              (clock),
        .rst                (rst),
        .split              (split),
        .read_addr_a        (read_addr_a),
        .read_addr_b        (read_addr_b),
        .write_addr_d       (write_addr_d),
        .read_ef_a          (read_ef_a),
        .read_ef_b          (read_ef_b),
        .write_ef_a         (write_ef_a),
        .write_ef_b         (write_ef_b),
        .io_rden_a          (io_rden_a),
        .io_rden_b          (io_rden_b),
        .read_addr_is_io_a  (read_addr_is_io_a),
        .read_addr_is_io_b  (read_addr_is_io_b),
        .write_addr_is_io_a (write_addr_is_io_a),
        .write_addr_is_io_b (write_addr_is_io_b),
        .io_ready           (io_ready)
    );

    always #(clock_period / 2) clock = ~clock;

    function automatic row_t make_row(
        input logic s, input logic [10:0] ra_a, input logic [10:0] ra_b,
        input logic [11:0] d, input port_vec_t ref_a, input port_vec_t ref_b,
        input port_vec_t wef_a, input port_vec_t wef_b, input port_vec_t rden_a,
        input port_vec_t rden_b, input logic [3:0] io, input logic ready);
        row_t r;
        r = '{s, ra_a, ra_b, d, ref_a, ref_b, wef_a, wef_b, rden_a, rden_b, io, ready};
        return r;
    endfunction

    // Reference model written straight from the address map and gate rules
    function automatic row_t apply_rules(row_t r);
        int   loc_ra;
        int   loc_rb;
        int   loc_wa;
        int   loc_wb;
        logic en_wa;
        logic en_wb;
        logic rio_a;
        logic rio_b;
        logic wio_a;
        logic wio_b;
        row_t e;
        e = r;
        loc_ra = int'(r.ra_a);
        loc_rb = int'(r.ra_b) - 1024;
        rio_a  = (r.ra_a < 1024) && (loc_ra >= 60);
        rio_b  = (r.ra_b >= 1024) && (loc_rb >= 60);
        if (r.split) begin
            en_wa  = 1'b1;
            en_wb  = 1'b1;
            loc_wa = int'(r.d) / 64;   // Upper six bits go to A
            loc_wb = int'(r.d) % 64;
        end else begin
            en_wa  = r.d < 1024;
            en_wb  = (r.d >= 1024) && (r.d < 2048);
            loc_wa = int'(r.d);
            loc_wb = int'(r.d) - 1024;
        end
        wio_a = en_wa && (loc_wa >= 60);
        wio_b = en_wb && (loc_wb >= 60);
        // Port index is the offset from 60, kept to its two bits
        e.ready = 1'b1;
        if (rio_a && !r.ref_a[(loc_ra - 60) & 3]) e.ready = 1'b0;
        if (rio_b && !r.ref_b[(loc_rb - 60) & 3]) e.ready = 1'b0;
        if (wio_a && !r.wef_a[(loc_wa - 60) & 3]) e.ready = 1'b0;
        if (wio_b && !r.wef_b[(loc_wb - 60) & 3]) e.ready = 1'b0;
        e.io     = {rio_a, rio_b, wio_a, wio_b};
        e.rden_a = '0;
        e.rden_b = '0;
        if (rio_a && e.ready) e.rden_a[(loc_ra - 60) & 3] = 1'b1;
        if (rio_b && e.ready) e.rden_b[(loc_rb - 60) & 3] = 1'b1;
        return e;
    endfunction

    // Addresses are pulled toward the port window so that I/O hits are common
    task automatic build_random_row(output row_t r);
        logic [31:0] v;
        logic [31:0] w;
        logic [31:0] x;
        r = '0;
        v = $random(seed);
        w = $random(seed);
        x = $random(seed);
        r.split = v[0];
        r.ra_a  = v[12:2];
        if (v[13]) r.ra_a[9:0] = 10'd60 + v[15:14];
        r.ra_b  = v[26:16];
        if (v[27]) r.ra_b[9:0] = 10'd60 + v[29:28];
        r.d     = w[11:0];
        if (w[12]) r.d[9:0] = 10'd60 + w[14:13];
        if (w[15]) r.d[5:0] = 6'd60 + w[17:16];
        if (w[18]) r.d[11:6] = 6'd60 + w[20:19];
        r.ref_a = x[3:0] | x[7:4];     // Flags mostly set
        r.ref_b = x[11:8] | x[15:12];
        r.wef_a = x[19:16] | x[23:20];
        r.wef_b = x[27:24] | x[31:28];
        r = apply_rules(r);
    endtask

    task automatic check_value(input string tag, input string field,
                               input logic [3:0] got, input logic [3:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0d ns: %s %s got %h expected %h", $time, tag, field, got, exp);
        end
    endtask

    task automatic compare_row(input row_t e, input string tag);
        check_value(tag, "io_rden_a", io_rden_a, e.rden_a);
        check_value(tag, "io_rden_b", io_rden_b, e.rden_b);
        check_value(tag, "read_addr_is_io_a", {3'b0, read_addr_is_io_a}, {3'b0, e.io[3]});
        check_value(tag, "read_addr_is_io_b", {3'b0, read_addr_is_io_b}, {3'b0, e.io[2]});
        check_value(tag, "write_addr_is_io_a", {3'b0, write_addr_is_io_a}, {3'b0, e.io[1]});
        check_value(tag, "write_addr_is_io_b", {3'b0, write_addr_is_io_b}, {3'b0, e.io[0]});
        check_value(tag, "io_ready", {3'b0, io_ready}, {3'b0, e.ready});
    endtask

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        row_t r;
        clock        = 1'b0;
        rst          = 1'b1;
        split        = 1'b0;
        // Port-window addresses during reset, so only the cleared register keeps the outputs idle
        read_addr_a  = 11'd61;
        read_addr_b  = 11'd1086;
        write_addr_d = 12'd1087;
        read_ef_a    = '0;
        read_ef_b    = '0;
        write_ef_a   = '0;
        write_ef_b   = '0;
        seed         = 32'h5b88_a04f;
        checks       = 0;
        errors       = 0;

        // Two reads on port windows, then an empty read port on B
        rows.push_back(make_row(1'b0, 11'd61, 11'd1086, 12'd20, 4'hf, 4'hf, 4'hf, 4'hf,
                                4'b0010, 4'b0100, 4'b1100, 1'b1));
        rows.push_back(make_row(1'b0, 11'd61, 11'd1086, 12'd20, 4'hf, 4'hb, 4'hf, 4'hf,
                                4'b0000, 4'b0000, 4'b1100, 1'b0));
        // Non-split write to B port 3, only write_ef_b bit 3 matters
        rows.push_back(make_row(1'b0, 11'd5, 11'd1029, 12'd1087, 4'hf, 4'hf, 4'hf, 4'hf,
                                4'b0000, 4'b0000, 4'b0001, 1'b1));
        rows.push_back(make_row(1'b0, 11'd5, 11'd1029, 12'd1087, 4'hf, 4'hf, 4'hf, 4'h7,
                                4'b0000, 4'b0000, 4'b0001, 1'b0));
        rows.push_back(make_row(1'b0, 11'd5, 11'd1029, 12'd1087, 4'h0, 4'h0, 4'h0, 4'h8,
                                4'b0000, 4'b0000, 4'b0001, 1'b1));
        rows.push_back(make_row(1'b0, 11'd5, 11'd1029, 12'd30, 4'h0, 4'h0, 4'h0, 4'h0,
                                4'b0000, 4'b0000, 4'b0000, 1'b1));
        // Split D with hi 60 and lo 63
        rows.push_back(make_row(1'b1, 11'd5, 11'd1029, 12'hf3f, 4'hf, 4'hf, 4'hf, 4'hf,
                                4'b0000, 4'b0000, 4'b0011, 1'b1));
        rows.push_back(make_row(1'b1, 11'd5, 11'd1029, 12'hf3f, 4'hf, 4'hf, 4'he, 4'hf,
                                4'b0000, 4'b0000, 4'b0011, 1'b0));
        rows.push_back(make_row(1'b1, 11'd5, 11'd1029, 12'hf3f, 4'h0, 4'h0, 4'h1, 4'h8,
                                4'b0000, 4'b0000, 4'b0011, 1'b1));
        rows.push_back(make_row(1'b1, 11'd5, 11'd1029, 12'hf3f, 4'hf, 4'hf, 4'hf, 4'h7,
                                4'b0000, 4'b0000, 4'b0011, 1'b0));
        rows.push_back(make_row(1'b1, 11'd63, 11'd1084, 12'hf3f, 4'hf, 4'hf, 4'hf, 4'hf,
                                4'b1000, 4'b0001, 4'b1111, 1'b1));
        // Reads aimed at the other memory and a D above both ranges
        rows.push_back(make_row(1'b0, 11'd1085, 11'd61, 12'd2111, 4'h0, 4'h0, 4'h0, 4'h0,
                                4'b0000, 4'b0000, 4'b0000, 1'b1));

        for (int i = 0; i < random_rows; i++) begin
            build_random_row(r);
            rows.push_back(r);
        end

        repeat (5) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        check_value("after reset", "io_rden_a", io_rden_a, 4'b0000);
        check_value("after reset", "io_rden_b", io_rden_b, 4'b0000);
        check_value("after reset", "is_io bits",
                    {read_addr_is_io_a, read_addr_is_io_b, write_addr_is_io_a,
                     write_addr_is_io_b}, 4'b0000);
        check_value("after reset", "io_ready", {3'b0, io_ready}, 4'b0001);

        // A new address goes in every cycle while the previous row gets its flags
        for (int k = 0; k <= rows.size(); k++) begin
            @(posedge clock);
            if (k < rows.size()) begin
                split        <= rows[k].split;
                read_addr_a  <= rows[k].ra_a;
                read_addr_b  <= rows[k].ra_b;
                write_addr_d <= rows[k].d;
            end
            if (k > 0) begin
                read_ef_a  <= rows[k-1].ref_a;
                read_ef_b  <= rows[k-1].ref_b;
                write_ef_a <= rows[k-1].wef_a;
                write_ef_b <= rows[k-1].wef_b;
            end
            @(negedge clock);
            if (k > 0) compare_row(rows[k-1], $sformatf("row %0d", k - 1));
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: files.f
design/io_addr_pkg.sv
design/io_port_pkg.sv
design/mem_address_decoder.sv
design/io_decode_stage.sv
design/io_ready_gate.sv
design/datapath_io_predication.sv
tb/tb_datapath_io_predication.sv

// File: Bender.yml
package:
  name: datapath_io_predication

sources:
  # Packages first, the decoder and gate use both
  - design/io_addr_pkg.sv
  - design/io_port_pkg.sv
  - design/mem_address_decoder.sv
  - design/io_decode_stage.sv
  - design/io_ready_gate.sv
  - design/datapath_io_predication.sv

  - target: test
    files:
      - tb/tb_datapath_io_predication.sv
